/* src.f */
+incdir+.
elk_bus_pkg.sv
elk_load_pkg.sv
bank_decoder.sv
cpu_bus_port.sv
rom_loader.sv
rom_arbiter.sv
sp_ram.sv
elk_mem_top.sv
elk_mem_checker.sv
elk_mem_assert.sv
tb_elk_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory system testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_elk_mem -f src.f -o sim_elk
./obj_dir/sim_elk 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation passed"

/* tb_elk_mem.sv */
`timescale 1ns/1ns
`include "elk_macros.svh"

module tb_elk_mem import elk_bus_pkg::*, elk_load_pkg::*; ();
	logic                   clk_sys = 1'b0;
	logic                   rst;
	logic                   core_reset;
	logic [`ELK_ADDR_W-1:0] core_addr;
	logic                   core_we_n;
	logic [`ELK_DATA_W-1:0] core_wdata;
	logic                   dl_active;
	logic                   dl_wr;
	logic [7:0]             dl_index;
	logic [`ELK_DL_AW-1:0]  dl_addr;
	logic [`ELK_DATA_W-1:0] dl_data;
	logic [`ELK_DATA_W-1:0] core_rdata;
	int                     errors;
	int                     checks;

	// one row is one clock of stimulus
	typedef struct packed {
		bus_op_t                op;
		logic                   wr;
		logic                   act;
		logic                   crst;
		logic [7:0]             idx;
		logic [`ELK_DL_AW-1:0]  addr;
		logic [`ELK_DATA_W-1:0] data;
	} row_t;

	row_t        rows[$];
	logic [31:0] lcg_state = 32'd57;
	int          cycle_limit = 0;
	int          cycles = 0;

	// 8 ns period
	always #4 clk_sys = ~clk_sys;

	elk_mem_top dut (.clk_sys(clk_sys), .rst(rst), .core_reset(core_reset),
		.core_addr(core_addr), .core_we_n(core_we_n), .core_wdata(core_wdata),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_index(dl_index), .dl_addr(dl_addr),
		.dl_data(dl_data), .core_rdata(core_rdata));

	elk_mem_checker u_checker (.clk_sys, .rst, .core_reset, .core_addr, .core_we_n,
		.core_wdata, .dl_active, .dl_wr, .dl_index, .dl_addr, .dl_data, .core_rdata,
		.errors, .checks);

	// next lcg byte from the upper half of the state
	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	// selector over offset zero extended to the download width
	function automatic logic [`ELK_DL_AW-1:0] bus_addr(logic [4:0] sel, logic [13:0] offs);
		return {6'd0, sel, offs};
	endfunction

	task automatic push_row(bus_op_t op, logic wr, logic act, logic crst, logic [7:0] idx,
		logic [`ELK_DL_AW-1:0] addr, logic [7:0] data);
		row_t r;
		r.op   = op;
		r.wr   = wr;
		r.act  = act;
		r.crst = crst;
		r.idx  = idx;
		r.addr = addr;
		r.data = data;
		rows.push_back(r);
	endtask

	task automatic idle(logic crst, logic act);
		push_row(OP_IDLE, 1'b0, act, crst, DL_ROM, '0, '0);
	endtask

	task automatic read_at(logic crst, logic [4:0] sel, logic [13:0] offs);
		push_row(OP_READ, 1'b0, 1'b0, crst, DL_ROM, bus_addr(sel, offs), '0);
	endtask

	task automatic write_at(logic [4:0] sel, logic [13:0] offs, logic [7:0] data);
		push_row(OP_WRITE, 1'b0, 1'b0, 1'b0, DL_ROM, bus_addr(sel, offs), data);
	endtask

	task automatic download(logic [7:0] idx, logic act, logic crst,
		logic [`ELK_DL_AW-1:0] addr, logic [7:0] data);
		push_row(OP_IDLE, 1'b1, act, crst, idx, addr, data);
	endtask

	task automatic build_table();
		logic [13:0] offs [3];
		logic [13:0] ram_off;
		logic [7:0]  val;
		val     = rand_byte();
		offs[0] = 14'h0000;
		offs[1] = 14'h3fff;
		offs[2] = {val[5:0], rand_byte()};
		val     = rand_byte();
		ram_off = {val[5:0], rand_byte()};
		////////////////////
		// rom image with the core held in reset
		////////////////////
		// loader needs dl_active a clock ahead
		idle(1'b1, 1'b1);
		for (int p = 0; p < `ELK_ROM_PAGES; p++) begin
			for (int k = 0; k < 3; k++) begin
				download(DL_ROM, 1'b1, 1'b1,
					25'((p << `ELK_PAGE_W) + int'(offs[k])), rand_byte());
			end
		end
		idle(1'b1, 1'b1);
		idle(1'b1, 1'b0);
		// rom belongs to the loader so reads give 0
		read_at(1'b1, 5'h04, offs[0]);
		read_at(1'b1, 5'h08, offs[1]);
		idle(1'b0, 1'b0);
		// every rom selector including the aliases
		for (int s = 4; s < 16; s++) begin
			if (s == 4 || s >= 8) begin
				for (int k = 0; k < 3; k++) begin
					read_at(1'b0, 5'(s), offs[k]);
				end
			end
		end
		// unmapped selectors
		for (int s = 0; s < 32; s++) begin
			if (s < 4 || (s > 4 && s < 8) || s >= 24) begin
				read_at(1'b0, 5'(s), offs[2]);
			end
		end
		////////////////////
		// sideways ram
		////////////////////
		// same offset on all pages and each keeps its own byte
		for (int p = 0; p < `ELK_RAM_PAGES; p++) begin
			write_at(5'(16 + p), ram_off, rand_byte());
			read_at(1'b0, 5'(16 + p), ram_off);
		end
		for (int p = 0; p < `ELK_RAM_PAGES; p++) begin
			read_at(1'b0, 5'(16 + p), ram_off);
		end
		for (int p = 0; p < `ELK_RAM_PAGES; p++) begin
			write_at(5'(16 + p), offs[2], rand_byte());
			read_at(1'b0, 5'(16 + p), offs[2]);
		end
		// core write into rom is dropped
		write_at(5'h0c, offs[0], rand_byte());
		read_at(1'b0, 5'h0c, offs[0]);
		// strobe held low over three data values
		write_at(5'h13, ram_off, rand_byte());
		write_at(5'h13, ram_off, rand_byte());
		write_at(5'h13, ram_off, rand_byte());
		read_at(1'b0, 5'h13, ram_off);
		////////////////////
		// downloads that must not land
		////////////////////
		idle(1'b1, 1'b1);
		download(DL_OTHER, 1'b1, 1'b1, 25'(offs[0]), rand_byte());
		idle(1'b1, 1'b1);
		idle(1'b1, 1'b0);
		download(DL_ROM, 1'b0, 1'b1, 25'((1 << `ELK_PAGE_W) + int'(offs[0])), rand_byte());
		idle(1'b1, 1'b0);
		idle(1'b0, 1'b1);
		download(DL_ROM, 1'b1, 1'b0, 25'((2 << `ELK_PAGE_W) + int'(offs[0])), rand_byte());
		idle(1'b0, 1'b1);
		idle(1'b0, 1'b0);
		read_at(1'b0, 5'h04, offs[0]);
		read_at(1'b0, 5'h08, offs[0]);
		read_at(1'b0, 5'h0a, offs[0]);
		idle(1'b0, 1'b0);
	endtask

	task automatic apply_row(row_t r);
		core_reset = r.crst;
		core_addr  = r.wr ? '0 : r.addr[`ELK_ADDR_W-1:0];
		core_we_n  = (r.op == OP_WRITE) ? 1'b0 : 1'b1;
		core_wdata = r.data;
		dl_active  = r.act;
		dl_wr      = r.wr;
		dl_index   = r.idx;
		dl_addr    = r.wr ? r.addr : '0;
		dl_data    = r.data;
	endtask

	initial begin
		rst        = 1'b1;
		core_reset = 1'b1;
		core_addr  = '0;
		core_we_n  = 1'b1;
		core_wdata = '0;
		dl_active  = 1'b0;
		dl_wr      = 1'b0;
		dl_index   = '0;
		dl_addr    = '0;
		dl_data    = '0;
		build_table();
		cycle_limit = 16 + 4 * rows.size() + 100;
		repeat (16) @(negedge clk_sys);
		rst = 1'b0;
		foreach (rows[i]) begin
			apply_row(rows[i]);
			@(negedge clk_sys);
		end
		// last compare happens on that falling edge
		@(posedge clk_sys);
		$display("reads checked %0d, mismatches %0d, assertion failures %0d",
			checks, errors, dut.u_assert.fail_count);
		if (errors == 0 && checks > 0 && dut.u_assert.fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		@(posedge clk_sys);
		while (cycles < cycle_limit) begin
			cycles++;
			@(posedge clk_sys);
		end
		$display("timeout, run still going after %0d cycles", cycle_limit);
		$display("Something failed");
		$finish;
	end

endmodule

/* elk_mem_assert.sv */
`timescale 1ns/1ns
`include "elk_macros.svh"

module elk_mem_assert (
	input logic                   clk_sys,
	input logic                   rst,
	input logic                   core_reset,
	input logic                   rom_we,
	input logic                   ram_we,
	input logic [`ELK_DATA_W-1:0] core_rdata
);
	// failed assertions so far
	int fail_count = 0;

	// rom only written by the loader while the core is held
	rom_we_in_reset: assert property (@(posedge clk_sys) disable iff (rst) rom_we |-> core_reset)
		else begin
			fail_count++;
			$error("rom write enable high while the core runs");
		end

	// one ram write per strobe
	ram_we_single: assert property (@(posedge clk_sys) disable iff (rst) ram_we |=> !ram_we)
		else begin
			fail_count++;
			$error("ram write enable high on two clocks in a row");
		end

	rdata_after_rst: assert property (@(posedge clk_sys) rst |=> core_rdata == '0)
		else begin
			fail_count++;
			$error("read data not zero after reset");
		end

endmodule

bind elk_mem_top elk_mem_assert u_assert (.clk_sys(clk_sys), .rst(rst),
	.core_reset(core_reset), .rom_we(rom_we), .ram_we(ram_we), .core_rdata(core_rdata));

/* elk_mem_checker.sv */
`timescale 1ns/1ns
`include "elk_macros.svh"

module elk_mem_checker import elk_bus_pkg::*, elk_load_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   core_reset,
	input  logic [`ELK_ADDR_W-1:0] core_addr,
	input  logic                   core_we_n,
	input  logic [`ELK_DATA_W-1:0] core_wdata,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [7:0]             dl_index,
	input  logic [`ELK_DL_AW-1:0]  dl_addr,
	input  logic [`ELK_DATA_W-1:0] dl_data,
	input  logic [`ELK_DATA_W-1:0] core_rdata,
	output int                     errors,
	output int                     checks
);
	localparam int PAGE = 1 << `ELK_PAGE_W;

	// sparse model, missing entries read as 0
	logic [`ELK_DATA_W-1:0] rom_m [int];
	logic [`ELK_DATA_W-1:0] ram_m [int];
	logic                   prev_we_n = 1'b1;
	logic                   exp_valid = 1'b0;
	logic [`ELK_DATA_W-1:0] exp_data;
	logic [`ELK_ADDR_W-1:0] exp_addr;
	int                     err_cnt = 0;
	int                     chk_cnt = 0;

	assign errors = err_cnt;
	assign checks = chk_cnt;

	// bank table, phys is the byte index in the page store
	function automatic bank_kind_t decode_bank(logic [`ELK_ADDR_W-1:0] a, output int phys);
		logic [4:0] sel;
		int         offs;
		sel  = a[`ELK_ADDR_W-1:`ELK_PAGE_W];
		offs = int'(a[`ELK_PAGE_W-1:0]);
		phys = 0;
		if (sel[4]) begin
			if (sel[3]) return BANK_NONE;
			phys = int'(sel[2:0]) * PAGE + offs;
			return BANK_RAM;
		end
		case (sel[3:2])
			2'b01: begin
				if (sel[1:0] != 2'b00) return BANK_NONE;
				phys = offs;
			end
			// pairs of selectors share a page
			2'b10: phys = (1 + int'(sel[1])) * PAGE + offs;
			2'b11: phys = (3 + int'(sel[1:0])) * PAGE + offs;
			default: return BANK_NONE;
		endcase
		return BANK_ROM;
	endfunction

	function automatic logic [`ELK_DATA_W-1:0] lookup_byte(logic [`ELK_ADDR_W-1:0] a);
		int         phys;
		bank_kind_t k;
		k = decode_bank(a, phys);
		if (k == BANK_ROM) return rom_m.exists(phys) ? rom_m[phys] : '0;
		if (k == BANK_RAM) return ram_m.exists(phys) ? ram_m[phys] : '0;
		return '0;
	endfunction

	////////////////////
	// model update and prediction
	////////////////////
	always @(posedge clk_sys) begin : model_update
		int         phys;
		bank_kind_t k;
		k = decode_bank(core_addr, phys);
		// first low clock of the strobe only
		if (!rst && !core_we_n && prev_we_n && k == BANK_RAM) begin
			ram_m[phys] = core_wdata;
		end
		// rom byte only from the rom download with the core held
		if (!rst && dl_wr && dl_active && dl_index == DL_ROM && core_reset) begin
			phys = int'(dl_addr[`ELK_ROM_AW-1:0]);
			if (phys < `ELK_ROM_PAGES * PAGE) rom_m[phys] = dl_data;
		end
		prev_we_n = rst ? 1'b1 : core_we_n;
		// write on this edge shows in the read
		exp_valid = 1'b1;
		exp_addr  = core_addr;
		exp_data  = (rst || core_reset) ? '0 : lookup_byte(core_addr);
	end

	// data is settled by the falling edge
	always @(negedge clk_sys) begin
		if (exp_valid) begin
			chk_cnt = chk_cnt + 1;
			if (core_rdata !== exp_data) begin
				err_cnt = err_cnt + 1;
				$display("Mismatch at %0t ns: address %h read %h, expected %h",
					$time, exp_addr, core_rdata, exp_data);
			end
		end
	end

endmodule

/* elk_mem_top.sv */
`timescale 1ns/1ns
`include "elk_macros.svh"

module elk_mem_top import elk_bus_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   core_reset,
	input  logic [`ELK_ADDR_W-1:0] core_addr,
	input  logic                   core_we_n,
	input  logic [`ELK_DATA_W-1:0] core_wdata,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [7:0]             dl_index,
	input  logic [`ELK_DL_AW-1:0]  dl_addr,
	input  logic [`ELK_DATA_W-1:0] dl_data,
	output logic [`ELK_DATA_W-1:0] core_rdata
);
	// decode
	bank_kind_t              kind;
	logic [`ELK_ROM_AW-1:0]  rom_addr;
	logic [`ELK_RAM_AW-1:0]  ram_addr;
	// rom side
	logic [`ELK_ROM_AW-1:0]  rom_rd_addr;
	logic [`ELK_ROM_AW-1:0]  rom_a;
	logic [`ELK_DATA_W-1:0]  rom_d;
	logic [`ELK_DATA_W-1:0]  rom_q;
	logic                    rom_we;
	// ram side
	logic [`ELK_RAM_AW-1:0]  ram_a;
	logic [`ELK_DATA_W-1:0]  ram_d;
	logic [`ELK_DATA_W-1:0]  ram_q;
	logic                    ram_we;
	// loader requests
	logic                    ld_req;
	logic [`ELK_ROM_AW-1:0]  ld_addr;
	logic [`ELK_DATA_W-1:0]  ld_data;

	bank_decoder u_decoder (.addr(core_addr), .kind, .rom_addr, .ram_addr);

	cpu_bus_port u_port (.clk_sys, .rst, .core_reset, .addr(core_addr), .we_n(core_we_n),
		.wdata(core_wdata), .kind, .rom_addr, .ram_addr, .rom_q, .ram_q,
		.rdata(core_rdata), .rom_rd_addr, .ram_we, .ram_a, .ram_d);

	rom_loader u_loader (.clk_sys, .rst, .dl_active, .dl_wr, .dl_index, .dl_addr,
		.dl_data, .ld_req, .ld_addr, .ld_data);

	rom_arbiter u_arbiter (.core_reset, .ld_req, .ld_addr, .ld_data, .rom_rd_addr,
		.rom_a, .rom_d, .rom_we);

	sp_ram #(.AW(`ELK_ROM_AW), .DEPTH(`ELK_ROM_PAGES << `ELK_PAGE_W), .DW(`ELK_DATA_W))
		rom_mem (.clk_sys, .a(rom_a), .d(rom_d), .we(rom_we), .q(rom_q));

	sp_ram #(.AW(`ELK_RAM_AW), .DEPTH(`ELK_RAM_PAGES << `ELK_PAGE_W), .DW(`ELK_DATA_W))
		ram_mem (.clk_sys, .a(ram_a), .d(ram_d), .we(ram_we), .q(ram_q));

endmodule

/* sp_ram.sv */
`timescale 1ns/1ns

module sp_ram #(
	parameter int AW    = 17,
	parameter int DEPTH = 1 << AW,
	parameter int DW    = 8
) (
	input  logic          clk_sys,
	input  logic [AW-1:0] a,
	input  logic [DW-1:0] d,
	input  logic          we,
	output logic [DW-1:0] q
);
	logic [DW-1:0] mem [0:DEPTH-1];
	// registered address, read follows it
	logic [AW-1:0] a_q;

	// contents start cleared
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		// writes past the last page go nowhere
		if (we && (32'(a) < DEPTH)) begin
			mem[a] <= d;
		end
		a_q <= a;
	end

	// same-clock write shows up as new data
	assign q = (32'(a_q) < DEPTH) ? mem[a_q] : '0;

endmodule

/* rom_arbiter.sv */
`timescale 1ns/1ns
`include "elk_macros.svh"

module rom_arbiter (
	input  logic                   core_reset,
	input  logic                   ld_req,
	input  logic [`ELK_ROM_AW-1:0] ld_addr,
	input  logic [`ELK_DATA_W-1:0] ld_data,
	input  logic [`ELK_ROM_AW-1:0] rom_rd_addr,
	output logic [`ELK_ROM_AW-1:0] rom_a,
	output logic [`ELK_DATA_W-1:0] rom_d,
	output logic                   rom_we
);

	////////////////////
	// rom ownership
	////////////////////

	// two requesters on one single-port array
	// loader while the core is held in reset
	// core port otherwise, read only
	always_comb begin
		if (core_reset) begin
			// loader drives address and write
			rom_a  = ld_addr;
			rom_we = ld_req;
		end else begin
			// core read address, loader requests are lost
			rom_a  = rom_rd_addr;
			rom_we = 1'b0;
		end
	end

	// only the loader ever writes the rom
	// core writes to rom selectors never reach here
	assign rom_d = ld_data;

	// no stall path back to either side
	// the loader only gets the array during core reset
	// and the core is not running then

endmodule

/* rom_loader.sv */
`timescale 1ns/1ns
`include "elk_macros.svh"

module rom_loader import elk_load_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [7:0]             dl_index,
	input  logic [`ELK_DL_AW-1:0]  dl_addr,
	input  logic [`ELK_DATA_W-1:0] dl_data,
	output logic                   ld_req,
	output logic [`ELK_ROM_AW-1:0] ld_addr,
	output logic [`ELK_DATA_W-1:0] ld_data
);
	load_state_t state;
	dl_target_t  target;
	// byte accepted this clock
	logic        take;

	// anything but index 0 is not ours
	assign target = (dl_index == DL_ROM) ? DL_ROM : DL_OTHER;
	assign take   = (state == LOAD_ACTIVE) && dl_wr && (target == DL_ROM);

	////////////////////
	// state follows dl_active
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= LOAD_IDLE;
		end else begin
			case (state)
				LOAD_IDLE:   if (dl_active) state <= LOAD_ACTIVE;
				LOAD_ACTIVE: if (!dl_active) state <= LOAD_IDLE;
				default:     state <= LOAD_IDLE;
			endcase
		end
	end

	// request strobe, one clock per accepted byte
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ld_req <= 1'b0;
		end else begin
			ld_req <= take;
		end
	end

	// payload, address cut down to rom width
	always_ff @(posedge clk_sys) begin
		if (take) begin
			ld_addr <= dl_addr[`ELK_ROM_AW-1:0];
			ld_data <= dl_data;
		end
	end

endmodule

/* cpu_bus_port.sv */
`timescale 1ns/1ns
`include "elk_macros.svh"

module cpu_bus_port import elk_bus_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   core_reset,
	input  logic [`ELK_ADDR_W-1:0] addr,
	input  logic                   we_n,
	input  logic [`ELK_DATA_W-1:0] wdata,
	input  bank_kind_t             kind,
	input  logic [`ELK_ROM_AW-1:0] rom_addr,
	input  logic [`ELK_RAM_AW-1:0] ram_addr,
	input  logic [`ELK_DATA_W-1:0] rom_q,
	input  logic [`ELK_DATA_W-1:0] ram_q,
	output logic [`ELK_DATA_W-1:0] rdata,
	output logic [`ELK_ROM_AW-1:0] rom_rd_addr,
	output logic                   ram_we,
	output logic [`ELK_RAM_AW-1:0] ram_a,
	output logic [`ELK_DATA_W-1:0] ram_d
);
	// strobe seen on the previous clock
	logic       we_n_q;
	// what the previous address pointed at
	bank_kind_t kind_q;
	bus_op_t    op;

	////////////////////
	// cycle type
	////////////////////
	always_comb begin
		if (we_n) begin
			op = OP_READ;
		end else if (we_n_q) begin
			// first low clock of the strobe
			op = OP_WRITE;
		end else begin
			// strobe still low, already written
			op = OP_IDLE;
		end
	end

	// one ram write per strobe, rom and unmapped writes dropped
	assign ram_we = (op == OP_WRITE) && (kind == BANK_RAM);
	assign ram_d  = wdata;

	// page from the decoder, offset straight from the core
	assign ram_a       = {ram_addr[`ELK_RAM_AW-1:`ELK_PAGE_W], addr[`ELK_PAGE_W-1:0]};
	assign rom_rd_addr = {rom_addr[`ELK_ROM_AW-1:`ELK_PAGE_W], addr[`ELK_PAGE_W-1:0]};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			we_n_q <= 1'b1;
			kind_q <= BANK_NONE;
		end else begin
			we_n_q <= we_n;
			// rom belongs to the loader during core reset, so read nothing
			kind_q <= core_reset ? BANK_NONE : kind;
		end
	end

	////////////////////
	// read data steering
	////////////////////
	always_comb begin
		case (kind_q)
			BANK_ROM: rdata = rom_q;
			BANK_RAM: rdata = ram_q;
			default:  rdata = '0;
		endcase
	end

endmodule

/* bank_decoder.sv */
`timescale 1ns/1ns
`include "elk_macros.svh"

module bank_decoder import elk_bus_pkg::*; (
	input  logic [`ELK_ADDR_W-1:0] addr,
	output bank_kind_t             kind,
	output logic [`ELK_ROM_AW-1:0] rom_addr,
	output logic [`ELK_RAM_AW-1:0] ram_addr
);
	localparam int SEL_W    = `ELK_ADDR_W - `ELK_PAGE_W;
	localparam int ROM_PG_W = `ELK_ROM_AW - `ELK_PAGE_W;
	localparam int RAM_PG_W = `ELK_RAM_AW - `ELK_PAGE_W;

	// bank selector and page offset
	logic [SEL_W-1:0]       sel;
	logic [`ELK_PAGE_W-1:0] offs;
	logic [ROM_PG_W-1:0]    rom_pg;
	logic                   rom_hit;
	logic                   ram_hit;

	assign sel  = addr[`ELK_ADDR_W-1:`ELK_PAGE_W];
	assign offs = addr[`ELK_PAGE_W-1:0];

	// ram lives at 1_00_xx and 1_01_xx, page is the low three bits
	assign ram_hit = sel[SEL_W-1] & ~sel[SEL_W-2];

	////////////////////
	// rom page table
	////////////////////
	always_comb begin
		rom_hit = 1'b1;
		case (sel)
			5'b0_01_00: rom_pg = ROM_PG_W'(0);
			// os image appears twice
			5'b0_10_00,
			5'b0_10_01: rom_pg = ROM_PG_W'(1);
			// basic also aliased
			5'b0_10_10,
			5'b0_10_11: rom_pg = ROM_PG_W'(2);
			5'b0_11_00: rom_pg = ROM_PG_W'(3);
			5'b0_11_01: rom_pg = ROM_PG_W'(4);
			5'b0_11_10: rom_pg = ROM_PG_W'(5);
			5'b0_11_11: rom_pg = ROM_PG_W'(6);
			default: begin
				rom_pg  = '0;
				rom_hit = 1'b0;
			end
		endcase
	end

	// ram wins, selectors never overlap anyway
	assign kind = ram_hit ? BANK_RAM : (rom_hit ? BANK_ROM : BANK_NONE);

	// physical addresses, only meaningful for the matching kind
	assign rom_addr = {rom_pg, offs};
	assign ram_addr = {sel[RAM_PG_W-1:0], offs};

endmodule

/* elk_load_pkg.sv */
package elk_load_pkg;

	// loader follows dl_active
	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_ACTIVE
	} load_state_t;

	// download index decode
	// index 0 is the rom image, anything else is for someone else
	typedef enum logic [7:0] {
		DL_ROM   = 8'd0,
		DL_OTHER = 8'd1
	} dl_target_t;

endpackage

/* elk_bus_pkg.sv */
package elk_bus_pkg;

	////////////////////
	// decode result
	////////////////////

	// what the current core address points at
	typedef enum logic [1:0] {
		BANK_NONE,
		BANK_ROM,
		BANK_RAM
	} bank_kind_t;

	////////////////////
	// core bus cycle
	////////////////////

	// idle also covers a strobe held low past its first clock
	typedef enum logic [1:0] {
		OP_IDLE,
		OP_READ,
		OP_WRITE
	} bus_op_t;

endpackage

/* elk_macros.svh */
`ifndef ELK_MACROS_SVH
`define ELK_MACROS_SVH

////////////////////
// core bus
////////////////////

// core address, 5-bit bank selector over 14-bit offset
`define ELK_ADDR_W 19
// byte wide data everywhere
`define ELK_DATA_W 8
// offset bits inside a 16 KB page
`define ELK_PAGE_W 14

////////////////////
// physical memories
////////////////////

// rom array, 3 page bits + offset
`define ELK_ROM_AW 17
// sideways ram, 3 page bits + offset
`define ELK_RAM_AW 17
`define ELK_ROM_PAGES 7
`define ELK_RAM_PAGES 8

// download host address, wider than any page store
`define ELK_DL_AW 25

`endif
